// ==== Bender.yml ====
package:
  name: stripe_store

# stripe_store_consts.svh lives in the project root
export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - stripe_store_pkg.sv
      - axi_fifobuf_write.sv
      - axi_stripe_writer.sv
      - stripe_bank.sv
      - stripe_store_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - stripe_store_tb.sv

// ==== axi_fifobuf_write.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stripe_store_consts.svh"

module axi_fifobuf_write
  import stripe_store_pkg::*;
#(
  parameter int DEPTH = `FIFO_DEPTH
) (
  input  logic axi_clk,
  input  logic arst_n,

  // joined write from the stripe writer
  input  wr_t  in_entry,
  input  logic in_valid,
  output logic in_ready,

  // entry towards the bank, address already local to the bank
  output wr_t  out_entry,
  output logic out_valid,
  input  logic out_ready,

  output logic empty,

  // bank response, always taken and then dropped
  input  b_t   bank_b,
  input  logic bank_b_valid,
  output logic bank_b_ready
);

  // pointers wrap on their own because DEPTH is a power of two
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  wr_t              mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;
  wr_t              head;

  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign empty     = (count == '0);
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  // the manager gets a constant OKAY, so bank responses are only sunk here
  assign bank_b_ready = 1'b1;

  // the head is read straight from the register array, so an entry
  // written at one edge is offered from the next cycle on
  assign head = mem[rd_ptr];

  // drop the bank select bits, the bank sees only its own word address
  assign out_entry.aw.addr = `ADDR_W'(head.aw.addr >> `SEL_W);
  assign out_entry.w       = head.w;

  // storage holds payload only and needs no reset
  always_ff @(posedge axi_clk) begin
    if (push) begin
      mem[wr_ptr] <= in_entry;
    end
  end

  always_ff @(posedge axi_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and pop leave the fill level unchanged
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the stripe writer offers a write only while every buffer has room,
  // so no push is ever aimed at a full buffer
  assert property (@(posedge axi_clk) disable iff (!arst_n)
    in_valid |-> in_ready);

  // an empty buffer has both pointers on the same slot,
  // so no pop has moved the read side past the written entries
  assert property (@(posedge axi_clk) disable iff (!arst_n)
    empty |-> (wr_ptr == rd_ptr));

  // the bank answers OKAY exactly one cycle after taking an entry
  assert property (@(posedge axi_clk) disable iff (!arst_n)
    bank_b_valid |-> $past(pop) && (bank_b == `RESP_OKAY));

endmodule

`default_nettype wire

// ==== axi_stripe_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stripe_store_consts.svh"

// spreads one manager write port over the bank FIFOs
// so that linear writes use the bandwidth of all banks together
module axi_stripe_writer
  import stripe_store_pkg::*;
(
  input  logic axi_clk,
  input  logic arst_n,

  // manager write port
  input  aw_t  aw,
  input  logic aw_valid,
  output logic aw_ready,
  input  w_t   w,
  input  logic w_valid,
  output logic w_ready,
  output b_t   b,
  output logic b_valid,
  input  logic b_ready,

  // one FIFO input per bank
  output wr_t  [`NUM_BANKS-1:0] buf_entry,
  output logic [`NUM_BANKS-1:0] buf_valid,
  input  logic [`NUM_BANKS-1:0] buf_ready
);

  logic              fully_ready;
  logic              beat_valid;
  logic [`SEL_W-1:0] bank_sel;
  wr_t               joined;

  // waiting for every FIFO keeps the ready logic trivial,
  // at the cost of stalling all banks when one of them is full
  assign fully_ready = &buf_ready;
  assign aw_ready    = fully_ready;
  assign w_ready     = fully_ready;

  // writes may finish out of order across banks, and without IDs no
  // per-write response can be returned, so the port answers OKAY at once
  assign b       = `RESP_OKAY;
  assign b_valid = 1'b1;

  // address and data are only taken together, so nothing has to be
  // held here while waiting for the other half of a write
  assign beat_valid = aw_valid && w_valid;
  assign bank_sel   = aw.addr[`SEL_W-1:0];

  assign joined.aw = aw;
  assign joined.w  = w;

  always_comb begin
    buf_valid = '0;
    for (int i = 0; i < `NUM_BANKS; i++) begin
      // every FIFO sees the same beat, only the valid picks the bank
      buf_entry[i] = joined;
      // the valid also waits for the common ready, otherwise a bank with
      // room would push a beat that the manager sees as not taken
      if (beat_valid && fully_ready && (bank_sel == `SEL_W'(i))) begin
        buf_valid[i] = 1'b1;
      end
    end
  end

  // at most one bank receives a given beat
  assert property (@(posedge axi_clk) disable iff (!arst_n)
    $onehot0(buf_valid));

  // both manager channels always stall and release together
  assert property (@(posedge axi_clk) disable iff (!arst_n)
    aw_ready == w_ready);

  // the manager does take the constant responses at some point
  cover property (@(posedge axi_clk) disable iff (!arst_n)
    b_valid && b_ready);

endmodule

`default_nettype wire

// ==== stripe_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stripe_store_consts.svh"

module stripe_bank
  import stripe_store_pkg::*;
(
  input  logic               axi_clk,
  input  logic               arst_n,

  // write channel from the bank FIFO, address already local
  input  wr_t                wr_entry,
  input  logic               wr_valid,
  output logic               wr_ready,

  // one response per accepted write
  output b_t                 b,
  output logic               b_valid,
  input  logic               b_ready,

  // read port, wins over a write in the same cycle
  input  logic               rd_en,
  input  logic [`BANK_AW-1:0] rd_addr,
  output logic [`DATA_W-1:0]  rd_data
);

  localparam int WORDS = 2 ** `BANK_AW;

  logic [`DATA_W-1:0]  mem [WORDS];
  logic [`BANK_AW-1:0] wr_addr;
  logic                wr_fire;

  // single ported storage, so a read blocks the write side for the cycle
  assign wr_ready = !rd_en;
  assign wr_fire  = wr_valid && wr_ready;
  assign wr_addr  = wr_entry.aw.addr[`BANK_AW-1:0];

  assign b = `RESP_OKAY;

  // only bytes with their strobe set are updated,
  // the others keep what was stored before
  always_ff @(posedge axi_clk) begin
    if (wr_fire) begin
      for (int i = 0; i < `STRB_W; i++) begin
        if (wr_entry.w.strb[i]) begin
          mem[wr_addr][8*i +: 8] <= wr_entry.w.data[8*i +: 8];
        end
      end
    end
  end

  // registered read data, valid one cycle after rd_en
  always_ff @(posedge axi_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  // response pulse follows the write edge by one cycle
  always_ff @(posedge axi_clk or negedge arst_n) begin
    if (!arst_n) begin
      b_valid <= 1'b0;
    end else begin
      b_valid <= wr_fire;
    end
  end

  // there is no response buffer here, so the FIFO has to take every pulse
  assert property (@(posedge axi_clk) disable iff (!arst_n)
    b_valid |-> b_ready);

endmodule

`default_nettype wire

// ==== stripe_store_consts.svh ====
`ifndef STRIPE_STORE_CONSTS_SVH
`define STRIPE_STORE_CONSTS_SVH

// word address width seen by the manager and the read port
`define ADDR_W 12

// data word width, always a whole number of bytes
`define DATA_W 16

// one strobe bit per data byte
`define STRB_W (`DATA_W / 8)

// number of banks the writes are striped over, a power of two
`define NUM_BANKS 4

// low address bits that pick the bank
`define SEL_W $clog2(`NUM_BANKS)

// word address width inside one bank
`define BANK_AW (`ADDR_W - `SEL_W)

// entries held per bank before back-pressure reaches the manager
`define FIFO_DEPTH 4

// AXI response code for a good write
`define RESP_OKAY 2'b00

`endif

// ==== stripe_store_pkg.sv ====
`default_nettype none

`include "stripe_store_consts.svh"

package stripe_store_pkg;

  // address beat of the manager write port
  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
  } aw_t;

  // data beat, data word first and its byte strobes below it
  typedef struct packed {
    logic [`DATA_W-1:0] data;
    logic [`STRB_W-1:0] strb;
  } w_t;

  // joined write as one FIFO entry, address in the upper bits
  typedef struct packed {
    aw_t aw;
    w_t  w;
  } wr_t;

  // write response code
  typedef logic [1:0] b_t;

  // read request, a full word address that still carries the bank bits
  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
  } rd_req_t;

  // read response word
  typedef struct packed {
    logic [`DATA_W-1:0] data;
  } rd_rsp_t;

endpackage

`default_nettype wire

// ==== stripe_store_stim.txt ====
# W addr data strb | R addr expected | I wait for wr_idle | X random ops
# A addr data strb cycles is an address beat without data; values hex, counts decimal
# linear writes over all four banks
W 000 1000 3
W 001 1101 3
W 002 1202 3
W 003 1303 3
W 004 1404 3
W 005 1505 3
W 006 1606 3
W 007 1707 3
W 008 1808 3
W 009 1909 3
W 00a 1a0a 3
W 00b 1b0b 3
W 00c 1c0c 3
W 00d 1d0d 3
W 00e 1e0e 3
W 00f 1f0f 3
I
R 000 1000
R 001 1101
R 002 1202
R 003 1303
R 004 1404
R 005 1505
R 006 1606
R 007 1707
R 008 1808
R 009 1909
R 00a 1a0a
R 00b 1b0b
R 00c 1c0c
R 00d 1d0d
R 00e 1e0e
R 00f 1f0f
# partial strobes merge with the old bytes
W 005 abcd 1
W 00a 77ff 2
I
R 005 15cd
R 00a 770a
# an all-zero strobe changes nothing
W 005 0000 0
W 00c ffff 0
I
R 005 15cd
R 00c 1c0c
# address without data must not be written
A 003 dead 3 6
I
R 003 1303
W 003 dead 3
I
R 003 dead
# random bursts with one bank kept busy by reads
X 300
X 200
I

// ==== stripe_store_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stripe_store_consts.svh"

module stripe_store_tb
  import stripe_store_pkg::*;
();

  localparam int WORDS = 2 ** `ADDR_W;

  logic    axi_clk;
  logic    arst_n;
  aw_t     aw;
  logic    aw_valid;
  logic    aw_ready;
  w_t      w;
  logic    w_valid;
  logic    w_ready;
  b_t      b;
  logic    b_valid;
  logic    b_ready;
  rd_req_t rd_req;
  logic    rd_valid;
  logic    rd_ready;
  rd_rsp_t rd_rsp;
  logic    rsp_valid;
  logic    wr_idle;

  // reference memory, updated only by writes that the DUT accepted
  logic [`DATA_W-1:0] model [WORDS];
  logic [31:0]        rng;
  int                 errors;
  int                 checks;
  int                 line_count;
  int                 random_ops;
  bit                 limit_known;
  bit                 saw_stall;
  bit                 had_burst;
  logic               prev_rd_acc;

  stripe_store_top i_dut (
    .axi_clk   (axi_clk),
    .arst_n    (arst_n),
    .aw        (aw),
    .aw_valid  (aw_valid),
    .aw_ready  (aw_ready),
    .w         (w),
    .w_valid   (w_valid),
    .w_ready   (w_ready),
    .b         (b),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .rd_req    (rd_req),
    .rd_valid  (rd_valid),
    .rd_ready  (rd_ready),
    .rd_rsp    (rd_rsp),
    .rsp_valid (rsp_valid),
    .wr_idle   (wr_idle)
  );

  always #20 axi_clk = ~axi_clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // merge a write into the reference memory byte by byte
  task automatic apply_model(input logic [`ADDR_W-1:0] a, input logic [`DATA_W-1:0] d,
                             input logic [`STRB_W-1:0] s);
    for (int i = 0; i < `STRB_W; i++) begin
      if (s[i]) begin
        model[a][8*i +: 8] = d[8*i +: 8];
      end
    end
  endtask

  // all driving tasks start and end 2 ns after a rising edge,
  // handshakes are sampled at the falling edge where everything is settled
  task automatic write_word(input logic [`ADDR_W-1:0] a, input logic [`DATA_W-1:0] d,
                            input logic [`STRB_W-1:0] s);
    aw.addr  = a;
    w.data   = d;
    w.strb   = s;
    aw_valid = 1'b1;
    w_valid  = 1'b1;
    @(negedge axi_clk);
    while (!aw_ready) begin
      @(negedge axi_clk);
    end
    apply_model(a, d, s);
    @(posedge axi_clk);
    #2;
    aw_valid = 1'b0;
    w_valid  = 1'b0;
  endtask

  task automatic wait_idle();
    @(negedge axi_clk);
    while (!wr_idle) begin
      @(negedge axi_clk);
    end
    @(posedge axi_clk);
    #2;
  endtask

  // one read, the word is checked in the cycle after the accepting edge
  task automatic check_read_data(input logic [`ADDR_W-1:0] a, input logic [`DATA_W-1:0] exp);
    rd_req.addr = a;
    rd_valid    = 1'b1;
    @(posedge axi_clk);
    #2;
    rd_valid = 1'b0;
    @(negedge axi_clk);
    checks++;
    if (rd_rsp.data !== exp) begin
      errors++;
      $display("FAILED rd_rsp.data at addr %h: expected %h, got %h", a, exp, rd_rsp.data);
    end
    @(posedge axi_clk);
    #2;
  endtask

  // address beat without its data, nothing may reach a FIFO meanwhile
  task automatic hold_address_only(input logic [`ADDR_W-1:0] a, input logic [`DATA_W-1:0] d,
                                   input logic [`STRB_W-1:0] s, input int n);
    aw.addr  = a;
    w.data   = d;
    w.strb   = s;
    aw_valid = 1'b1;
    w_valid  = 1'b0;
    repeat (n) begin
      @(negedge axi_clk);
      checks++;
      if (wr_idle !== 1'b1) begin
        errors++;
        $display("FAILED wr_idle during address-only beat: expected 1, got %h", wr_idle);
      end
      @(posedge axi_clk);
      #2;
    end
    aw_valid = 1'b0;
  endtask

  // random writes while most cycles read from one hot bank,
  // then a drain and a full read back against the model
  task automatic random_burst(input int n);
    logic [`SEL_W-1:0] hot;
    logic              pending;
    int                k;
    rng       = xorshift(rng);
    hot       = rng[`SEL_W-1:0];
    pending   = 1'b0;
    had_burst = 1'b1;
    k         = 0;
    while (k < n || pending) begin
      if (!pending && k < n) begin
        rng = xorshift(rng);
        // half of the writes go to the hot bank so that its FIFO fills
        aw.addr  = rng[8] ? `ADDR_W'({rng[3:2], hot}) : `ADDR_W'(rng[3:0]);
        w.data   = rng[31:16];
        w.strb   = rng[5:4];
        aw_valid = rng[9] | rng[10];
        w_valid  = aw_valid;
        pending  = aw_valid;
      end
      rng         = xorshift(rng);
      rd_valid    = (k < n) && (rng[2:0] != 3'd0);
      rd_req.addr = `ADDR_W'({rng[5:4], hot});
      @(negedge axi_clk);
      if (pending && aw_ready) begin
        apply_model(aw.addr, w.data, w.strb);
        pending = 1'b0;
      end
      @(posedge axi_clk);
      #2;
      if (!pending) begin
        aw_valid = 1'b0;
        w_valid  = 1'b0;
      end
      k++;
    end
    rd_valid = 1'b0;
    wait_idle();
    for (int a = 0; a < 16; a++) begin
      check_read_data(`ADDR_W'(a), model[a]);
    end
  endtask

  // the dry pass only counts lines and random operations for the watchdog
  task automatic run_stimulus(input bit dry);
    int                 fd;
    int                 code;
    int                 n;
    logic [63:0]        tok;
    logic [8*256-1:0]   rest;
    logic [`ADDR_W-1:0] a;
    logic [`DATA_W-1:0] d;
    logic [`STRB_W-1:0] s;
    fd = $fopen("stripe_store_stim.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the stimulus file stripe_store_stim.txt");
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok == "#") begin
          code = $fgets(rest, fd);
        end else begin
          if (dry) begin
            line_count++;
          end
          case (tok)
            "W": begin
              code = $fscanf(fd, "%h %h %h", a, d, s);
              if (!dry) begin
                write_word(a, d, s);
              end
            end
            "R": begin
              code = $fscanf(fd, "%h %h", a, d);
              if (!dry) begin
                checks++;
                if (model[a] !== d) begin
                  errors++;
                  $display("FAILED model at addr %h: expected %h, got %h", a, d, model[a]);
                end
                check_read_data(a, d);
              end
            end
            "I": begin
              if (!dry) begin
                wait_idle();
              end
            end
            "A": begin
              code = $fscanf(fd, "%h %h %h %d", a, d, s, n);
              if (!dry) begin
                hold_address_only(a, d, s, n);
              end
            end
            "X": begin
              code = $fscanf(fd, "%d", n);
              if (dry) begin
                random_ops += n;
              end else begin
                random_burst(n);
              end
            end
            default: begin
              if (dry) begin
                errors++;
                $display("unknown line type in the stimulus file");
              end
            end
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  // continuous checks on the response channel, ready pairing and read timing
  always @(negedge axi_clk) begin
    if (arst_n) begin
      if (b_valid !== 1'b1) begin
        errors++;
        $display("FAILED b_valid: expected 1, got %h", b_valid);
      end
      // OKAY is the all-zero code
      if (b !== 2'b00) begin
        errors++;
        $display("FAILED b: expected 0, got %h", b);
      end
      if (aw_ready !== w_ready) begin
        errors++;
        $display("FAILED w_ready: expected %h, got %h", aw_ready, w_ready);
      end
      // reads are never stalled
      if (rd_ready !== 1'b1) begin
        errors++;
        $display("FAILED rd_ready: expected 1, got %h", rd_ready);
      end
      if (rsp_valid !== prev_rd_acc) begin
        errors++;
        $display("FAILED rsp_valid: expected %h, got %h", prev_rd_acc, rsp_valid);
      end
      if (aw_ready === 1'b0) begin
        saw_stall = 1'b1;
      end
      prev_rd_acc = rd_valid && rd_ready;
    end else begin
      prev_rd_acc = 1'b0;
    end
  end

  initial begin
    wait (limit_known);
    repeat (200 * line_count + 50 * random_ops + 20) begin
      @(posedge axi_clk);
    end
    $display("timeout, the run did not finish in the allowed number of cycles");
    $display("checks: %0d, errors: %0d", checks, errors + 1);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    axi_clk     = 1'b0;
    arst_n      = 1'b0;
    aw          = '0;
    aw_valid    = 1'b0;
    w           = '0;
    w_valid     = 1'b0;
    b_ready     = 1'b1;
    rd_req      = '0;
    rd_valid    = 1'b0;
    rng         = 32'd44802;
    errors      = 0;
    checks      = 0;
    line_count  = 0;
    random_ops  = 0;
    saw_stall   = 1'b0;
    had_burst   = 1'b0;
    prev_rd_acc = 1'b0;
    run_stimulus(1'b1);
    limit_known = 1'b1;
    repeat (5) begin
      @(posedge axi_clk);
    end
    #2;
    arst_n = 1'b1;
    @(negedge axi_clk);
    checks++;
    if (wr_idle !== 1'b1 || rsp_valid !== 1'b0 || aw_ready !== 1'b1) begin
      errors++;
      $display("FAILED reset state: wr_idle %h rsp_valid %h aw_ready %h",
               wr_idle, rsp_valid, aw_ready);
    end
    @(posedge axi_clk);
    #2;
    if (errors == 0) begin
      run_stimulus(1'b0);
    end
    // back-pressure has to show up at least once while reads steal a bank
    if (had_burst && !saw_stall) begin
      errors++;
      $display("aw_ready never fell during the random bursts");
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== stripe_store_top.f ====
+incdir+.
stripe_store_pkg.sv
axi_fifobuf_write.sv
axi_stripe_writer.sv
stripe_bank.sv
stripe_store_top.sv
stripe_store_tb.sv

// ==== stripe_store_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stripe_store_consts.svh"

module stripe_store_top
  import stripe_store_pkg::*;
(
  input  logic    axi_clk,
  input  logic    arst_n,

  // manager write port
  input  aw_t     aw,
  input  logic    aw_valid,
  output logic    aw_ready,
  input  w_t      w,
  input  logic    w_valid,
  output logic    w_ready,
  output b_t      b,
  output logic    b_valid,
  input  logic    b_ready,

  // read port over all banks
  input  rd_req_t rd_req,
  input  logic    rd_valid,
  output logic    rd_ready,
  output rd_rsp_t rd_rsp,
  output logic    rsp_valid,

  // high when no write is left in any FIFO
  output logic    wr_idle
);

  wr_t  [`NUM_BANKS-1:0]              buf_entry;
  logic [`NUM_BANKS-1:0]              buf_valid;
  logic [`NUM_BANKS-1:0]              buf_ready;
  wr_t  [`NUM_BANKS-1:0]              bank_entry;
  logic [`NUM_BANKS-1:0]              bank_valid;
  logic [`NUM_BANKS-1:0]              bank_ready;
  b_t   [`NUM_BANKS-1:0]              bank_b;
  logic [`NUM_BANKS-1:0]              bank_b_valid;
  logic [`NUM_BANKS-1:0]              bank_b_ready;
  logic [`NUM_BANKS-1:0]              fifo_empty;
  logic [`NUM_BANKS-1:0]              bank_rd_en;
  logic [`NUM_BANKS-1:0][`DATA_W-1:0] bank_rd_data;
  logic [`SEL_W-1:0]                  rd_bank;
  logic [`SEL_W-1:0]                  rd_bank_q;
  logic [`BANK_AW-1:0]                rd_baddr;

  axi_stripe_writer i_writer (
    .axi_clk   (axi_clk),
    .arst_n    (arst_n),
    .aw        (aw),
    .aw_valid  (aw_valid),
    .aw_ready  (aw_ready),
    .w         (w),
    .w_valid   (w_valid),
    .w_ready   (w_ready),
    .b         (b),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .buf_entry (buf_entry),
    .buf_valid (buf_valid),
    .buf_ready (buf_ready)
  );

  // same split as on the write side, low bits pick the bank
  assign rd_bank  = rd_req.addr[`SEL_W-1:0];
  assign rd_baddr = rd_req.addr[`ADDR_W-1:`SEL_W];

  // reads never wait, a read simply steals the bank from its FIFO
  assign rd_ready = 1'b1;

  for (genvar i = 0; i < `NUM_BANKS; i++) begin : gen_bank
    assign bank_rd_en[i] = rd_valid && (rd_bank == `SEL_W'(i));

    axi_fifobuf_write #(
      .DEPTH (`FIFO_DEPTH)
    ) i_fifo (
      .axi_clk      (axi_clk),
      .arst_n       (arst_n),
      .in_entry     (buf_entry[i]),
      .in_valid     (buf_valid[i]),
      .in_ready     (buf_ready[i]),
      .out_entry    (bank_entry[i]),
      .out_valid    (bank_valid[i]),
      .out_ready    (bank_ready[i]),
      .empty        (fifo_empty[i]),
      .bank_b       (bank_b[i]),
      .bank_b_valid (bank_b_valid[i]),
      .bank_b_ready (bank_b_ready[i])
    );

    stripe_bank i_bank (
      .axi_clk  (axi_clk),
      .arst_n   (arst_n),
      .wr_entry (bank_entry[i]),
      .wr_valid (bank_valid[i]),
      .wr_ready (bank_ready[i]),
      .b        (bank_b[i]),
      .b_valid  (bank_b_valid[i]),
      .b_ready  (bank_b_ready[i]),
      .rd_en    (bank_rd_en[i]),
      .rd_addr  (rd_baddr),
      .rd_data  (bank_rd_data[i])
    );
  end

  // idle only once every bank has drained its buffered writes
  assign wr_idle = &fifo_empty;

  // the bank index travels with the read so the right word is picked
  always_ff @(posedge axi_clk) begin
    if (rd_valid) begin
      rd_bank_q <= rd_bank;
    end
  end

  always_ff @(posedge axi_clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= rd_valid && rd_ready;
    end
  end

  assign rd_rsp.data = bank_rd_data[rd_bank_q];

endmodule

`default_nettype wire
